// File: design/rsa_data_pkg.sv
package rsa_data_pkg;

  // operand element width
  localparam int DATA_W = 16;
  // full product of two elements
  localparam int PROD_W = 2 * DATA_W;
  // guard bits on top of the product
  // 16 worst-case beats before overflow
  localparam int GUARD_W = 4;
  localparam int ACC_W = PROD_W + GUARD_W;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // per-beat operation on the accumulators
  typedef enum logic [1:0] {
    OP_NEW = 2'd0,
    OP_ACC = 2'd1,
    OP_SUB = 2'd2
  } op_e;

endpackage

// File: design/rsa_ctrl_pkg.sv
package rsa_ctrl_pkg;

  import rsa_data_pkg::*;

  // command riding with each input beat
  typedef struct packed {
    op_e  op;
    logic last;
  } cmd_t;

  // registered control into the array and the drain stage
  typedef struct packed {
    logic en;
    logic clear;
    logic negate;
    logic last;
  } pe_ctrl_t;

  // input side, hold blocks beats during a drain
  typedef enum logic {ST_ACCEPT = 1'b0, ST_HOLD = 1'b1} dec_state_e;

  // output side, rows leave only in send
  typedef enum logic {DR_IDLE = 1'b0, DR_SEND = 1'b1} drain_state_e;

endpackage

// File: design/rsa_decode.sv
`timescale 1ns/1ps

module rsa_decode
  import rsa_data_pkg::*;
  import rsa_ctrl_pkg::*;
#(
  parameter int X = 4,
  parameter int Y = 4
) (
  input  logic                clk,
  input  logic                sys_rst,
  input  logic                i_valid,
  input  cmd_t                i_cmd,
  input  data_t [X-1:0]       i_a,
  input  data_t [Y-1:0]       i_b,
  input  logic                i_drain_done,
  output logic                o_ready,
  output data_t [X-1:0]       o_a,
  output data_t [Y-1:0]       o_b,
  output pe_ctrl_t            o_ctrl
);

  dec_state_e    state;
  logic          accept;
  pe_ctrl_t      ctrl_d;
  pe_ctrl_t      ctrl_q;
  data_t [X-1:0] a_q;
  data_t [Y-1:0] b_q;

  // ready straight from the state register
  assign o_ready = (state == ST_ACCEPT);
  assign accept  = i_valid && o_ready;

  // op to array control
  always_comb begin
    ctrl_d      = '0;
    ctrl_d.en   = 1'b1;
    ctrl_d.last = i_cmd.last;
    unique case (i_cmd.op)
      // load product, drop old sum
      OP_NEW: ctrl_d.clear = 1'b1;
      OP_ACC: ctrl_d.clear = 1'b0;
      // add the negated product
      OP_SUB: ctrl_d.negate = 1'b1;
      default: ctrl_d.en = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state  <= ST_ACCEPT;
      ctrl_q <= '0;
    end else begin
      // en lasts one cycle per accepted beat
      ctrl_q <= accept ? ctrl_d : '0;
      case (state)
        ST_ACCEPT: if (accept && i_cmd.last) state <= ST_HOLD;
        // reopen once the last row has gone out
        ST_HOLD:   if (i_drain_done) state <= ST_ACCEPT;
        default:   state <= ST_ACCEPT;
      endcase
    end
  end

  // operand registers
  always_ff @(posedge clk) begin
    if (accept) begin
      a_q <= i_a;
      b_q <= i_b;
    end
  end

  assign o_a    = a_q;
  assign o_b    = b_q;
  assign o_ctrl = ctrl_q;

  // after a last beat, nothing gets in until the drain ends
  a_no_beat_in_hold: assert property (@(posedge clk) disable iff (sys_rst)
    (accept && i_cmd.last) |=> (!accept until i_drain_done));

endmodule

// File: design/rsa_pe_mac.sv
`timescale 1ns/1ps

module rsa_pe_mac
  import rsa_data_pkg::*;
  import rsa_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,
  input  data_t    i_a,
  input  data_t    i_b,
  input  pe_ctrl_t i_ctrl,
  output acc_t     o_acc
);

  prod_t prod;
  acc_t  term;
  acc_t  acc_q;

  // signed 16x16 product
  assign prod = i_a * i_b;
  // sign-extend to accumulator width, flip for subtract
  assign term = i_ctrl.negate ? -acc_t'(prod) : acc_t'(prod);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      acc_q <= '0;
    end else if (i_ctrl.en) begin
      // clear loads the product as the new sum
      acc_q <= i_ctrl.clear ? term : acc_q + term;
    end
  end

  assign o_acc = acc_q;

  // decode only raises clear together with a beat
  a_clear_needs_en: assert property (@(posedge clk) disable iff (sys_rst)
    i_ctrl.clear |-> i_ctrl.en);

endmodule

// File: design/rsa_pe_array.sv
`timescale 1ns/1ps

module rsa_pe_array
  import rsa_data_pkg::*;
  import rsa_ctrl_pkg::*;
#(
  parameter int X = 4,
  parameter int Y = 4
) (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  data_t [X-1:0]         i_a,
  input  data_t [Y-1:0]         i_b,
  input  pe_ctrl_t              i_ctrl,
  output acc_t  [X-1:0][Y-1:0]  o_acc
);

  // outer-product grid
  // a element broadcast along its row, like the west feed
  // b element broadcast down its column, like the south feed
  // one shared control word for every element
  for (genvar r = 0; r < X; r++) begin : g_row
    for (genvar c = 0; c < Y; c++) begin : g_col
      rsa_pe_mac u_pe (
        .clk     (clk),
        .sys_rst (sys_rst),
        // row operand
        .i_a     (i_a[r]),
        // column operand
        .i_b     (i_b[c]),
        .i_ctrl  (i_ctrl),
        .o_acc   (o_acc[r][c])
      );
    end
  end

endmodule

// File: design/rsa_result.sv
`timescale 1ns/1ps

module rsa_result
  import rsa_data_pkg::*;
  import rsa_ctrl_pkg::*;
#(
  parameter int X = 4,
  parameter int Y = 4,
  localparam int IW = (X > 1) ? $clog2(X) : 1
) (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  pe_ctrl_t              i_ctrl,
  input  acc_t  [X-1:0][Y-1:0]  i_acc,
  input  logic                  i_row_ready,
  output logic                  o_row_valid,
  output acc_t  [Y-1:0]         o_row,
  output logic  [IW-1:0]        o_row_idx,
  output logic                  o_row_last,
  output logic                  o_drain_done
);

  drain_state_e  state;
  logic [IW-1:0] row_cnt;
  logic          row_fire;

  assign o_row_valid = (state == DR_SEND);
  assign row_fire    = o_row_valid && i_row_ready;

  // current row straight off the accumulators
  // grid is frozen during a drain, so the row holds under back-pressure
  assign o_row      = i_acc[row_cnt];
  assign o_row_idx  = row_cnt;
  assign o_row_last = (row_cnt == IW'(X - 1));
  // handshake of the final row
  assign o_drain_done = row_fire && o_row_last;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state   <= DR_IDLE;
      row_cnt <= '0;
    end else begin
      case (state)
        DR_IDLE: begin
          row_cnt <= '0;
          // last beat lands in the grid on this edge
          if (i_ctrl.en && i_ctrl.last) state <= DR_SEND;
        end
        DR_SEND: begin
          if (row_fire) begin
            if (o_row_last) begin
              state   <= DR_IDLE;
              row_cnt <= '0;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end
        end
        default: state <= DR_IDLE;
      endcase
    end
  end

  // stalled row keeps its index
  a_row_hold: assert property (@(posedge clk) disable iff (sys_rst)
    (o_row_valid && !i_row_ready) |=> (o_row_valid && $stable(o_row_idx)));

  // decode must keep beats out while rows drain
  a_no_en_in_drain: assert property (@(posedge clk) disable iff (sys_rst)
    o_row_valid |-> !i_ctrl.en);

endmodule

// File: design/rsa_top.sv
`timescale 1ns/1ps

module rsa_top
  import rsa_data_pkg::*;
  import rsa_ctrl_pkg::*;
#(
  parameter int X = 4,
  parameter int Y = 4,
  localparam int IW = (X > 1) ? $clog2(X) : 1
) (
  input  logic           clk,
  input  logic           sys_rst,
  input  logic           i_valid,
  input  cmd_t           i_cmd,
  input  data_t [X-1:0]  i_a,
  input  data_t [Y-1:0]  i_b,
  input  logic           i_row_ready,
  output logic           o_ready,
  output logic           o_row_valid,
  output acc_t  [Y-1:0]  o_row,
  output logic  [IW-1:0] o_row_idx,
  output logic           o_row_last
);

  // registered operands and control
  data_t [X-1:0]         a_q;
  data_t [Y-1:0]         b_q;
  pe_ctrl_t              ctrl_q;
  // full accumulator matrix
  acc_t  [X-1:0][Y-1:0]  acc;
  // end of drain back to the input side
  logic                  drain_done;

  rsa_decode #(.X(X), .Y(Y)) u_decode (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_valid      (i_valid),
    .i_cmd        (i_cmd),
    .i_a          (i_a),
    .i_b          (i_b),
    .i_drain_done (drain_done),
    .o_ready      (o_ready),
    .o_a          (a_q),
    .o_b          (b_q),
    .o_ctrl       (ctrl_q)
  );

  rsa_pe_array #(.X(X), .Y(Y)) u_pe_array (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_a     (a_q),
    .i_b     (b_q),
    .i_ctrl  (ctrl_q),
    .o_acc   (acc)
  );

  rsa_result #(.X(X), .Y(Y)) u_result (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_ctrl       (ctrl_q),
    .i_acc        (acc),
    .i_row_ready  (i_row_ready),
    .o_row_valid  (o_row_valid),
    .o_row        (o_row),
    .o_row_idx    (o_row_idx),
    .o_row_last   (o_row_last),
    .o_drain_done (drain_done)
  );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_sys_rst
);

  // 10 ns period
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // reset high over the first 5 rising edges
  initial begin
    o_sys_rst = 1'b1;
    repeat (5) @(posedge o_clk);
    o_sys_rst <= 1'b0;
  end

endmodule

// File: verification/tb_rsa.sv
`timescale 1ns/1ps

module tb_rsa
  import rsa_data_pkg::*;
  import rsa_ctrl_pkg::*;
#(
  parameter int X = 4,
  parameter int Y = 4
);

  localparam int IW = $clog2(X);
  localparam int N_TESTS = 5;
  // fixed, subtract, back-pressure, two products of 8
  localparam int N_BEATS = 3 + 3 + 4 + 16;
  localparam int CYCLE_LIMIT = N_BEATS + N_TESTS * (4 * X + 40);

  logic           clk;
  logic           sys_rst;
  logic           i_valid;
  cmd_t           i_cmd;
  data_t [X-1:0]  i_a;
  data_t [Y-1:0]  i_b;
  logic           i_row_ready;
  logic           o_ready;
  logic           o_row_valid;
  acc_t  [Y-1:0]  o_row;
  logic  [IW-1:0] o_row_idx;
  logic           o_row_last;

  // expected accumulator matrix
  acc_t        model [X][Y];
  logic [15:0] lfsr;
  int          errors;
  int          tests_pass;
  int          tests_fail;
  int          cycles = 0;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_sys_rst(sys_rst));

  rsa_top #(.X(X), .Y(Y)) DUT (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_valid     (i_valid),
    .i_cmd       (i_cmd),
    .i_a         (i_a),
    .i_b         (i_b),
    .i_row_ready (i_row_ready),
    .o_ready     (o_ready),
    .o_row_valid (o_row_valid),
    .o_row       (o_row),
    .o_row_idx   (o_row_idx),
    .o_row_last  (o_row_last)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic random_bit();
    logic [15:0] v;
    v = take_bits(1);
    return v[0];
  endfunction

  function automatic op_e random_op();
    return random_bit() ? OP_SUB : OP_ACC;
  endfunction

  // new loads, acc adds, sub subtracts, all mod 2^36
  function automatic void model_beat(input op_e op, input data_t [X-1:0] a,
                                     input data_t [Y-1:0] b);
    prod_t pa;
    prod_t pb;
    acc_t  p;
    for (int r = 0; r < X; r++) begin
      for (int c = 0; c < Y; c++) begin
        pa = a[r];
        pb = b[c];
        p  = pa * pb;
        case (op)
          OP_NEW:  model[r][c] = p;
          OP_ACC:  model[r][c] = model[r][c] + p;
          default: model[r][c] = model[r][c] - p;
        endcase
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [35:0] expected,
                             input logic [35:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic send_beat(input op_e op, input logic last,
                           input data_t [X-1:0] a, input data_t [Y-1:0] b);
    cmd_t cmd;
    cmd.op   = op;
    cmd.last = last;
    i_valid <= 1'b1;
    i_cmd   <= cmd;
    i_a     <= a;
    i_b     <= b;
    // transfer on the first edge that sees ready
    @(posedge clk);
    while (!o_ready) @(posedge clk);
    model_beat(op, a, b);
  endtask

  task automatic send_random_beat(input op_e op, input logic last);
    data_t [X-1:0] a;
    data_t [Y-1:0] b;
    for (int r = 0; r < X; r++)
      a[r] = take_bits(16);
    for (int c = 0; c < Y; c++)
      b[c] = take_bits(16);
    send_beat(op, last, a, b);
  endtask

  // drain all rows, ready from lfsr bits when bp is set
  task automatic collect_rows(input bit bp);
    int             row;
    int             n_edge;
    bit             waiting;
    logic  [IW-1:0] held_idx;
    acc_t  [Y-1:0]  held_row;
    row     = 0;
    n_edge  = 0;
    waiting = 0;
    i_valid     <= 1'b0;
    i_row_ready <= bp ? random_bit() : 1'b1;
    while (row < X) begin
      @(posedge clk);
      n_edge++;
      check_value("o_ready during drain", 36'h0, o_ready);
      // first row two cycles after the last beat, then valid until the drain ends
      check_value("o_row_valid", n_edge >= 2, o_row_valid);
      if (o_row_valid) begin
        if (waiting) begin
          check_value("o_row_idx while stalled", held_idx, o_row_idx);
          for (int c = 0; c < Y; c++)
            check_value($sformatf("o_row[%0d] while stalled", c), held_row[c], o_row[c]);
        end
        if (i_row_ready) begin
          check_value("o_row_idx", row, o_row_idx);
          check_value("o_row_last", row == X - 1, o_row_last);
          for (int c = 0; c < Y; c++)
            check_value($sformatf("o_row[%0d] of row %0d", c, row), model[row][c], o_row[c]);
          row++;
          waiting = 0;
        end else begin
          waiting  = 1;
          held_idx = o_row_idx;
          held_row = o_row;
        end
      end
      i_row_ready <= bp ? random_bit() : 1'b1;
    end
    // input reopens one cycle after the last row
    @(posedge clk);
    check_value("o_ready after drain", 36'h1, o_ready);
  endtask

  task automatic test_reset();
    @(posedge clk);
    while (sys_rst) @(posedge clk);
    check_value("o_ready", 36'h1, o_ready);
    check_value("o_row_valid", 36'h0, o_row_valid);
  endtask

  task automatic test_fixed();
    data_t [X-1:0] a;
    data_t [Y-1:0] b;
    for (int k = 0; k < 3; k++) begin
      for (int r = 0; r < X; r++)
        a[r] = data_t'(r + k + 1);
      for (int c = 0; c < Y; c++)
        b[c] = data_t'(c - 2 * k + 1);
      send_beat((k == 0) ? OP_NEW : OP_ACC, k == 2, a, b);
    end
    collect_rows(1'b0);
  endtask

  task automatic test_subtract();
    data_t [X-1:0] a;
    data_t [Y-1:0] b;
    // force the sign bit so the first beat is all negative on a
    for (int r = 0; r < X; r++)
      a[r] = take_bits(16) | 16'h8000;
    for (int c = 0; c < Y; c++)
      b[c] = take_bits(16);
    send_beat(OP_NEW, 1'b0, a, b);
    send_random_beat(OP_SUB, 1'b0);
    send_random_beat(OP_ACC, 1'b1);
    collect_rows(1'b0);
  endtask

  task automatic test_backpressure();
    send_random_beat(OP_NEW, 1'b0);
    for (int k = 1; k < 4; k++)
      send_random_beat(random_op(), k == 3);
    collect_rows(1'b1);
  endtask

  // second product opens with new, so nothing of the first survives
  task automatic test_back_to_back();
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 8; k++)
        send_random_beat((k == 0) ? OP_NEW : random_op(), k == 7);
      collect_rows(1'b0);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_pass++;
      $display("test %s: pass", name);
    end else begin
      tests_fail++;
      $display("test %s: FAIL with %0d errors", name, errors - errors_before);
    end
  endtask

  // cycle budget, and the input must stay shut while rows drain
  always @(posedge clk) begin
    cycles++;
    if (!sys_rst && o_row_valid && o_ready) begin
      $display("input is open while a result drains, cycle %0d", cycles);
      errors++;
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin : main_seq
    int mark;
    errors      = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    lfsr        = 16'd44728;
    i_valid     = 1'b0;
    i_cmd       = '0;
    i_a         = '0;
    i_b         = '0;
    i_row_ready = 1'b0;
    mark = errors;
    test_reset();
    end_test("reset", mark);
    mark = errors;
    test_fixed();
    end_test("fixed product", mark);
    mark = errors;
    test_subtract();
    end_test("subtract", mark);
    mark = errors;
    test_backpressure();
    end_test("back-pressure", mark);
    mark = errors;
    test_back_to_back();
    end_test("back-to-back", mark);
    $display("tests passed %0d, tests failed %0d", tests_pass, tests_fail);
    if (errors == 0 && tests_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sim.f
design/rsa_data_pkg.sv
design/rsa_ctrl_pkg.sv
design/rsa_decode.sv
design/rsa_pe_mac.sv
design/rsa_pe_array.sv
design/rsa_result.sv
design/rsa_top.sv
verification/tb_clk_gen.sv
verification/tb_rsa.sv

// File: Bender.yml
package:
  name: rsa

sources:
  - files:
      - design/rsa_data_pkg.sv
      - design/rsa_ctrl_pkg.sv
      - design/rsa_decode.sv
      - design/rsa_pe_mac.sv
      - design/rsa_pe_array.sv
      - design/rsa_result.sv
      - design/rsa_top.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_rsa.sv
